// File: Bender.yml
package:
  name: tinker_core

export_include_dirs:
  - include

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/fetch_unit.sv
  - src/register_file.sv
  - src/decode_stage.sv
  - src/operand_bypass.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/tinker_core.sv
  - target: test
    files:
      - tests/tb_tinker_core.sv

// File: include/tinker_defines.svh
// Tinker core build constants
// Widths, register count and fetch parameters shared by the RTL

`ifndef TINKER_DEFINES_SVH
`define TINKER_DEFINES_SVH

// Data path and instruction widths
`define TINKER_XLEN          64
`define TINKER_INST_W        32

// Architectural register file
`define TINKER_REG_COUNT     32

// Fetch
`define TINKER_RESET_PC      64'h2000
`define TINKER_PC_STEP       4

// Operands per instruction that go through the bypass network (rs, rt, rd)
`define TINKER_NUM_OPERANDS  3

`endif

// File: src/decode_stage.sv
// Tinker decode stage
// Field split, control decode, register read and the decode/execute register

`timescale 1ns/1ps
`include "tinker_defines.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  isa_pkg::word_t         pc,
    input  isa_pkg::inst_word_t    inst,
    input  logic                   squash,
    input  pipe_pkg::result_fwd_t  wb,
    output pipe_pkg::operand_src_t operands [`TINKER_NUM_OPERANDS],
    input  isa_pkg::word_t         bypassed [`TINKER_NUM_OPERANDS],
    output pipe_pkg::dex_t         dex,
    output isa_pkg::word_t         ex_ops [`TINKER_NUM_OPERANDS]
);
    isa_pkg::opcode_t   opcode;
    isa_pkg::reg_addr_t rd;
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    isa_pkg::literal_t  lit;
    isa_pkg::reg_addr_t rs_eff;
    isa_pkg::reg_addr_t rf_addr [`TINKER_NUM_OPERANDS];
    isa_pkg::word_t     rf_data [`TINKER_NUM_OPERANDS];
    pipe_pkg::ctrl_t    ctrl;
    pipe_pkg::dex_t     dex_d;

    assign opcode = isa_pkg::opcode_t'(inst[31:27]);
    assign rd     = inst[26:22];
    assign rs     = inst[21:17];
    assign rt     = inst[16:12];
    assign lit    = inst[11:0];

    // ##################################################################
    // Control decode
    // ##################################################################

    always_comb begin
        ctrl   = '0;
        rs_eff = rs;
        case (opcode)
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
            isa_pkg::OP_XOR, isa_pkg::OP_NOT, isa_pkg::OP_SHFTR, isa_pkg::OP_SHFTL,
            isa_pkg::OP_MOV_REG: begin
                ctrl.alu_en    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // Immediate forms read and write rd
            isa_pkg::OP_ADDI, isa_pkg::OP_SUBI, isa_pkg::OP_SHFTRI, isa_pkg::OP_SHFTLI,
            isa_pkg::OP_MOV_LIT: begin
                ctrl.alu_en    = 1'b1;
                ctrl.reg_write = 1'b1;
                rs_eff         = rd;
            end
            isa_pkg::OP_MOV_MEM: begin
                ctrl.alu_en     = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            isa_pkg::OP_MOV_STR: begin
                ctrl.alu_en    = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            isa_pkg::OP_BR, isa_pkg::OP_BRR, isa_pkg::OP_BRRI, isa_pkg::OP_BRNZ,
            isa_pkg::OP_BRGT: begin
                ctrl.alu_en = 1'b1;
            end
            isa_pkg::OP_PRIV: begin
                ctrl.alu_en = (lit == '0);
            end
            // Multiply, divide, float, call and return do nothing
            default: ;
        endcase
        // R0 is never written, so it is never forwarded either
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    // Operand order A = rs, B = rt, C = rd
    assign rf_addr[0] = rs_eff;
    assign rf_addr[1] = rt;
    assign rf_addr[2] = rd;

    register_file u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rd_addr (rf_addr),
        .rd_data (rf_data),
        .wr      (wb)
    );

    always_comb begin
        for (int i = 0; i < `TINKER_NUM_OPERANDS; i++) begin
            operands[i] = '{idx: rf_addr[i], value: rf_data[i]};
        end
    end

    assign dex_d = '{
        pc:      pc,
        opcode:  opcode,
        rd:      rd,
        literal: {{(`TINKER_XLEN-12){lit[11]}}, lit},
        ctrl:    ctrl
    };

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dex <= '0;
            for (int i = 0; i < `TINKER_NUM_OPERANDS; i++) begin
                ex_ops[i] <= '0;
            end
        end else begin
            dex <= squash ? '0 : dex_d;
            for (int i = 0; i < `TINKER_NUM_OPERANDS; i++) begin
                ex_ops[i] <= bypassed[i];
            end
        end
    end

endmodule

// File: src/execute_stage.sv
// Tinker execute stage
// ALU, address generation and branch evaluation, then the execute/memory register

`timescale 1ns/1ps
`include "tinker_defines.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  squash,
    input  pipe_pkg::dex_t        dex,
    input  isa_pkg::word_t        ops [`TINKER_NUM_OPERANDS],
    output pipe_pkg::result_fwd_t ex_fwd,
    output pipe_pkg::exm_t        exm
);
    isa_pkg::word_t  op_a;
    isa_pkg::word_t  op_b;
    isa_pkg::word_t  op_c;
    isa_pkg::shamt_t shamt;
    logic            use_literal;
    pipe_pkg::exm_t  exm_d;

    // Literal takes the place of rt
    always_comb begin
        case (dex.opcode)
            isa_pkg::OP_ADDI, isa_pkg::OP_SUBI, isa_pkg::OP_SHFTRI, isa_pkg::OP_SHFTLI,
            isa_pkg::OP_MOV_MEM, isa_pkg::OP_MOV_LIT, isa_pkg::OP_BRRI: use_literal = 1'b1;
            default: use_literal = 1'b0;
        endcase
    end

    assign op_a  = ops[0];
    assign op_b  = use_literal ? dex.literal : ops[1];
    assign op_c  = ops[2];
    assign shamt = op_b[5:0];

    // ##################################################################
    // ALU and branch unit
    // ##################################################################

    always_comb begin
        exm_d      = '0;
        exm_d.rd   = dex.rd;
        exm_d.ctrl = dex.ctrl;
        if (dex.ctrl.alu_en) begin
            case (dex.opcode)
                isa_pkg::OP_ADD, isa_pkg::OP_ADDI:     exm_d.result = op_a + op_b;
                isa_pkg::OP_SUB, isa_pkg::OP_SUBI:     exm_d.result = op_a - op_b;
                isa_pkg::OP_AND:                       exm_d.result = op_a & op_b;
                isa_pkg::OP_OR:                        exm_d.result = op_a | op_b;
                isa_pkg::OP_XOR:                       exm_d.result = op_a ^ op_b;
                isa_pkg::OP_NOT:                       exm_d.result = ~op_a;
                isa_pkg::OP_SHFTR, isa_pkg::OP_SHFTRI: exm_d.result = $signed(op_a) >>> shamt;
                isa_pkg::OP_SHFTL, isa_pkg::OP_SHFTLI: exm_d.result = op_a << shamt;
                isa_pkg::OP_MOV_REG:                   exm_d.result = op_a;
                // Only the low 12 bits of rd are replaced
                isa_pkg::OP_MOV_LIT: exm_d.result = {op_a[`TINKER_XLEN-1:12], op_b[11:0]};
                isa_pkg::OP_MOV_MEM: exm_d.mem_addr = op_a + op_b;
                isa_pkg::OP_MOV_STR: begin
                    exm_d.mem_addr   = op_c + dex.literal;
                    exm_d.store_data = op_a;
                end
                isa_pkg::OP_BR: begin
                    exm_d.br_taken  = 1'b1;
                    exm_d.br_target = op_c;
                end
                isa_pkg::OP_BRR: begin
                    exm_d.br_taken  = 1'b1;
                    exm_d.br_target = dex.pc + op_c;
                end
                isa_pkg::OP_BRRI: begin
                    exm_d.br_taken  = 1'b1;
                    exm_d.br_target = dex.pc + op_b;
                end
                isa_pkg::OP_BRNZ: begin
                    exm_d.br_taken  = (op_a != '0);
                    exm_d.br_target = op_c;
                end
                isa_pkg::OP_BRGT: begin
                    exm_d.br_taken  = ($signed(op_a) > $signed(op_b));
                    exm_d.br_target = op_c;
                end
                // Decode only enables PRIV when the literal is zero
                isa_pkg::OP_PRIV: exm_d.halt = 1'b1;
                default: ;
            endcase
        end
    end

    assign ex_fwd = '{valid: dex.ctrl.reg_write, idx: dex.rd, value: exm_d.result};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exm <= '0;
        end else if (squash) begin
            exm <= '0;
        end else begin
            exm <= exm_d;
        end
    end

endmodule

// File: src/fetch_unit.sv
// Tinker fetch unit
// Program counter and the fetch/decode pipeline register

`timescale 1ns/1ps
`include "tinker_defines.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::redirect_t redirect,
    output isa_pkg::word_t      imem_addr,
    input  isa_pkg::inst_word_t imem_data,
    output isa_pkg::word_t      dec_pc,
    output isa_pkg::inst_word_t dec_inst
);
    isa_pkg::word_t pc_q;

    assign imem_addr = pc_q;

    // Sequential step unless the memory stage resolved a taken branch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_q <= `TINKER_RESET_PC;
        end else if (redirect.taken) begin
            pc_q <= redirect.target;
        end else begin
            pc_q <= pc_q + `TINKER_PC_STEP;
        end
    end

    // All-zero word decodes to AND r0 and never writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_pc   <= '0;
            dec_inst <= '0;
        end else if (redirect.taken) begin
            dec_pc   <= '0;
            dec_inst <= '0;
        end else begin
            dec_pc   <= pc_q;
            dec_inst <= imem_data;
        end
    end

endmodule

// File: src/isa_pkg.sv
// Tinker instruction-set types
// Data words, instruction fields and the opcode map

`include "tinker_defines.svh"

package isa_pkg;

    typedef logic [`TINKER_XLEN-1:0]               word_t;
    typedef logic [`TINKER_INST_W-1:0]             inst_word_t;
    typedef logic [$clog2(`TINKER_REG_COUNT)-1:0]  reg_addr_t;
    typedef logic [11:0]                           literal_t;
    typedef logic [5:0]                            shamt_t;

    // Opcode map, bits [31:27] of the instruction
    typedef enum logic [4:0] {
        OP_AND     = 5'h00,
        OP_OR      = 5'h01,
        OP_XOR     = 5'h02,
        OP_NOT     = 5'h03,
        OP_SHFTR   = 5'h04,
        OP_SHFTRI  = 5'h05,
        OP_SHFTL   = 5'h06,
        OP_SHFTLI  = 5'h07,
        OP_BR      = 5'h08,
        OP_BRR     = 5'h09,
        OP_BRRI    = 5'h0A,
        OP_BRNZ    = 5'h0B,
        OP_CALL    = 5'h0C,
        OP_RETURN  = 5'h0D,
        OP_BRGT    = 5'h0E,
        OP_PRIV    = 5'h0F,
        OP_MOV_MEM = 5'h10,
        OP_MOV_REG = 5'h11,
        OP_MOV_LIT = 5'h12,
        OP_MOV_STR = 5'h13,
        OP_ADDF    = 5'h14,
        OP_SUBF    = 5'h15,
        OP_MULF    = 5'h16,
        OP_DIVF    = 5'h17,
        OP_ADD     = 5'h18,
        OP_ADDI    = 5'h19,
        OP_SUB     = 5'h1A,
        OP_SUBI    = 5'h1B,
        OP_MUL     = 5'h1C,
        OP_DIV     = 5'h1D
    } opcode_t;

endpackage

// File: src/memory_stage.sv
// Tinker memory/writeback stage
// Drives the data port, selects writeback data and resolves branches

`timescale 1ns/1ps

module memory_stage (
    input  pipe_pkg::exm_t        exm,
    output pipe_pkg::dmem_req_t   dmem_req,
    input  isa_pkg::word_t        dmem_rdata,
    output pipe_pkg::result_fwd_t wb,
    output pipe_pkg::redirect_t   redirect,
    output logic                  hlt
);
    isa_pkg::word_t wb_value;

    assign dmem_req = '{
        addr:  exm.mem_addr,
        wdata: exm.store_data,
        rd:    exm.ctrl.mem_read,
        wr:    exm.ctrl.mem_write
    };

    // Loads return data in the same cycle
    assign wb_value = exm.ctrl.mem_to_reg ? dmem_rdata : exm.result;

    assign wb       = '{valid: exm.ctrl.reg_write, idx: exm.rd, value: wb_value};
    assign redirect = '{taken: exm.br_taken, target: exm.br_target};
    assign hlt      = exm.halt;

endmodule

// File: src/operand_bypass.sv
// Tinker operand bypass
// Picks the newest value of one source register

`timescale 1ns/1ps

module operand_bypass (
    input  pipe_pkg::operand_src_t src,
    input  pipe_pkg::result_fwd_t  ex_fwd,
    input  pipe_pkg::result_fwd_t  mem_fwd,
    output isa_pkg::word_t         value
);
    logic hit_ex;
    logic hit_mem;

    assign hit_ex  = ex_fwd.valid && (ex_fwd.idx == src.idx);
    assign hit_mem = mem_fwd.valid && (mem_fwd.idx == src.idx);

    // Execute holds the younger result, so it wins
    always_comb begin
        if (hit_ex) begin
            value = ex_fwd.value;
        end else if (hit_mem) begin
            value = mem_fwd.value;
        end else begin
            value = src.value;
        end
    end

endmodule

// File: src/pipe_pkg.sv
// Tinker pipeline payloads
// Structs passed between the stages and out to the memory ports

package pipe_pkg;

    // One operand as read in decode, before bypass
    typedef struct packed {
        isa_pkg::reg_addr_t idx;
        isa_pkg::word_t     value;
    } operand_src_t;

    // A result on its way to the register file
    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t idx;
        isa_pkg::word_t     value;
    } result_fwd_t;

    typedef struct packed {
        logic alu_en;
        logic mem_read;
        logic mem_write;
        logic reg_write;
        logic mem_to_reg;
    } ctrl_t;

    // ##################################################################
    // Stage registers
    // ##################################################################

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::opcode_t   opcode;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     literal;
        ctrl_t              ctrl;
    } dex_t;

    typedef struct packed {
        isa_pkg::word_t     result;
        isa_pkg::word_t     mem_addr;
        isa_pkg::word_t     store_data;
        isa_pkg::word_t     br_target;
        logic               br_taken;
        logic               halt;
        isa_pkg::reg_addr_t rd;
        ctrl_t              ctrl;
    } exm_t;

    typedef struct packed {
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
        logic           rd;
        logic           wr;
    } dmem_req_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } redirect_t;

endpackage

// File: src/register_file.sv
// Tinker register file
// 32 x 64-bit, three combinational read ports and one write port

`timescale 1ns/1ps
`include "tinker_defines.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  isa_pkg::reg_addr_t    rd_addr [`TINKER_NUM_OPERANDS],
    output isa_pkg::word_t        rd_data [`TINKER_NUM_OPERANDS],
    input  pipe_pkg::result_fwd_t wr
);
    isa_pkg::word_t regs [`TINKER_REG_COUNT];

    // R0 is hardwired to zero
    always_comb begin
        for (int i = 0; i < `TINKER_NUM_OPERANDS; i++) begin
            if (rd_addr[i] == '0) begin
                rd_data[i] = '0;
            end else begin
                rd_data[i] = regs[rd_addr[i]];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.idx] <= wr.value;
        end
    end

endmodule

// File: src/tinker_core.sv
// Tinker core top level
// Four-stage pipeline with external instruction and data ports

`timescale 1ns/1ps
`include "tinker_defines.svh"

module tinker_core (
    input  logic                clk,
    input  logic                reset,
    output isa_pkg::word_t      imem_addr,
    input  isa_pkg::inst_word_t imem_data,
    output pipe_pkg::dmem_req_t dmem_req,
    input  isa_pkg::word_t      dmem_rdata,
    output logic                hlt
);
    isa_pkg::word_t         dec_pc;
    isa_pkg::inst_word_t    dec_inst;
    pipe_pkg::operand_src_t operands [`TINKER_NUM_OPERANDS];
    isa_pkg::word_t         bypassed [`TINKER_NUM_OPERANDS];
    isa_pkg::word_t         ex_ops   [`TINKER_NUM_OPERANDS];
    pipe_pkg::dex_t         dex;
    pipe_pkg::exm_t         exm;
    pipe_pkg::result_fwd_t  ex_fwd;
    pipe_pkg::result_fwd_t  wb;
    pipe_pkg::redirect_t    redirect;

    fetch_unit u_fetch (
        .clk       (clk),
        .reset     (reset),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dec_pc    (dec_pc),
        .dec_inst  (dec_inst)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .pc       (dec_pc),
        .inst     (dec_inst),
        .squash   (redirect.taken),
        .wb       (wb),
        .operands (operands),
        .bypassed (bypassed),
        .dex      (dex),
        .ex_ops   (ex_ops)
    );

    // One bypass per source operand
    for (genvar g = 0; g < `TINKER_NUM_OPERANDS; g++) begin : g_bypass
        operand_bypass u_bypass (
            .src     (operands[g]),
            .ex_fwd  (ex_fwd),
            .mem_fwd (wb),
            .value   (bypassed[g])
        );
    end

    execute_stage u_execute (
        .clk    (clk),
        .reset  (reset),
        .squash (redirect.taken),
        .dex    (dex),
        .ops    (ex_ops),
        .ex_fwd (ex_fwd),
        .exm    (exm)
    );

    memory_stage u_memory (
        .exm        (exm),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .wb         (wb),
        .redirect   (redirect),
        .hlt        (hlt)
    );

endmodule

// File: tb.f
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/register_file.sv
src/decode_stage.sv
src/operand_bypass.sv
src/execute_stage.sv
src/memory_stage.sv
src/tinker_core.sv
tests/tb_tinker_core.sv

// File: tests/program_vectors.txt
# P addr count words... | D addr data | F cycle addr | S addr data | H stores
# Cycle 0 is the first cycle after reset, values in hex except counts and cycles
P 2000 4 90400005 C8400003 C0821000 38800004
P 2010 4 D0C41000 98060100 19060000 29000004
P 2020 4 98080108 C0021000 98000110 01482000
P 2030 4 094A1000 218A1000 D9800003 31CC1000
P 2040 4 8A0E0000 98100118 82440080 928007FF
# BRRI at 2054, squashed stores behind it
P 2050 4 98920020 50000010 980201F8 980201F8
P 2060 4 980201F8 48400000 980201F8 8B040000
P 2070 4 3B000005 930000A0 43000000 980201F8
P 2080 2 980201F8 980201F8
# BRNZ falls through, BRGT taken
P 20A0 4 5B000000 98180128 8B580000 CB400040
P 20B0 4 73426000 980201F8 980201F8 980201F8
P 20E0 2 981A0130 78000000
D 180 0123456789ABCDEF
F 0 2000
F 1 2004
F 21 2054
F 24 2060
F 25 2064
F 28 2070
F 29 206C
F 32 2078
F 35 2084
F 36 20A0
F 40 20B0
F 43 20BC
F 44 20E0
S 100 00000000000000F8
S 108 FFFFFFFFFFFFFFF0
S 110 0000000000000000
S 118 FFFFFFFFFFFFFE00
S 120 0123456789ABCDEF
S 128 00000000000020A0
S 130 00000000000020E0
H 7

// File: tests/tb_tinker_core.sv
// Testbench for the Tinker core
// Models instruction and data memory, runs the program from the vectors file
// and checks fetch addresses, stores and the halt pulse

`timescale 1ns/1ps
`include "tinker_defines.svh"

module tb_tinker_core;

    logic                  clk;
    logic                  reset;
    isa_pkg::word_t        imem_addr;
    isa_pkg::inst_word_t   imem_data;
    pipe_pkg::dmem_req_t   dmem_req;
    isa_pkg::word_t        dmem_rdata;
    logic                  hlt;

    // Memory models with 256 entries each
    isa_pkg::inst_word_t   imem [256];
    isa_pkg::word_t        dmem [256];
    isa_pkg::word_t        imem_off;

    // Expected results from the vectors file
    int                    fetch_cycle [$];
    isa_pkg::word_t        fetch_addr  [$];
    isa_pkg::word_t        store_addr  [$];
    isa_pkg::word_t        store_data  [$];
    int                    halt_stores;
    int                    prog_words;

    tinker_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .hlt        (hlt)
    );

    always #10 clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_off   = imem_addr - `TINKER_RESET_PC;
    assign imem_data  = (imem_off < 1024) ? imem[imem_off[9:2]] : '0;
    assign dmem_rdata = dmem[dmem_req.addr[10:3]];

    always @(posedge clk) begin
        if (!reset && dmem_req.wr) begin
            dmem[dmem_req.addr[10:3]] <= dmem_req.wdata;
        end
    end

    // ##################################################################
    // Checks
    // ##################################################################

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_halt(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // ##################################################################
    // Vector reader
    // ##################################################################

    task automatic load_vectors();
        int             fd;
        int             rc;
        int             count;
        int             cyc;
        logic [7:0]     kind;
        string          line;
        isa_pkg::word_t addr;
        isa_pkg::word_t data;
        fd = $fopen("tests/program_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open tests/program_vectors.txt");
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": rc = $fgets(line, fd);
                "P": begin
                    rc = $fscanf(fd, "%h %d", addr, count);
                    for (int i = 0; i < count; i++) begin
                        rc = $fscanf(fd, "%h", data);
                        imem[((addr - `TINKER_RESET_PC) >> 2) + i] = data[31:0];
                        prog_words++;
                    end
                end
                "D": begin
                    rc = $fscanf(fd, "%h %h", addr, data);
                    dmem[addr[10:3]] = data;
                end
                "F": begin
                    rc = $fscanf(fd, "%d %h", cyc, addr);
                    fetch_cycle.push_back(cyc);
                    fetch_addr.push_back(addr);
                end
                "S": begin
                    rc = $fscanf(fd, "%h %h", addr, data);
                    store_addr.push_back(addr);
                    store_data.push_back(data);
                end
                "H": rc = $fscanf(fd, "%d", halt_stores);
                default: stop_on_error($sformatf("Unknown record kind '%c' in vectors", kind));
            endcase
        end
        $fclose(fd);
    endtask

    // Watchdog sized from the program length
    initial begin
        @(negedge reset);
        repeat (40 * prog_words) @(posedge clk);
        $display("Watchdog expired: the core never raised hlt");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

    initial begin
        int cycle;
        int fptr;
        int sidx;
        logic halted;
        clk         = 1'b0;
        reset       = 1'b1;
        prog_words  = 0;
        halt_stores = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = {32'hD00D_0000 | i, 32'h0 | (i << 3)};
        end
        load_vectors();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (dmem_req.rd || dmem_req.wr || hlt) begin
            stop_on_error("Data strobes or hlt not low right after reset");
        end

        cycle  = 0;
        fptr   = 0;
        sidx   = 0;
        halted = 1'b0;
        while (!halted) begin
            while (fptr < fetch_cycle.size() && fetch_cycle[fptr] == cycle) begin
                check_word($sformatf("fetch address at cycle %0d", cycle),
                           fetch_addr[fptr], imem_addr);
                fptr++;
            end
            if (dmem_req.wr) begin
                if (sidx >= store_addr.size()) begin
                    stop_on_error($sformatf("Unexpected store to %h at cycle %0d",
                                            dmem_req.addr, cycle));
                end
                check_addr($sformatf("store %0d address", sidx), store_addr[sidx], dmem_req.addr);
                check_word($sformatf("store %0d data", sidx), store_data[sidx], dmem_req.wdata);
                sidx++;
            end
            if (hlt) begin
                check_halt("stores before halt", halt_stores, sidx);
                check_halt("store records seen", store_addr.size(), sidx);
                halted = 1'b1;
            end else begin
                @(negedge clk);
                cycle++;
            end
        end
        if (fptr != fetch_cycle.size()) begin
            stop_on_error("Halt came before every fetch address was checked");
        end

        // hlt lasts a single cycle
        @(negedge clk);
        if (hlt) begin
            stop_on_error("hlt stayed high for more than one cycle");
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
